/* Makefile */
# Verilator build of the fetch front end testbench.
BIN  := obj_dir/Vfetch_tb
SRCS := $(filter-out +%,$(shell cat list.f)) logic/fetch_config.svh

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST RESULT: PASS'

$(BIN): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
		-f list.f -o Vfetch_tb

clean:
	rm -rf obj_dir

/* list.f */
+incdir+logic
logic/fetch_pkg.sv
logic/imem_bank.sv
logic/rastack.sv
logic/ifetch.sv
logic/axil_imem_loader.sv
logic/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_tb.sv

/* logic/axil_imem_loader.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module axil_imem_loader
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t req,
    output axil_rsp_t rsp,
    output imem_wr_t  wr
);

    localparam int WORD_LIMIT = 4 * `IMEM_DEPTH;

    logic                bvalid_q;
    axil_resp_e          bresp_q;
    logic                rvalid_q;

    logic                aw_fire;
    logic                ar_fire;
    logic [`AXIL_AW-3:0] word_idx;
    logic                in_range;
    logic                strb_ok;
    logic                wr_ok;

    // ---------------------------------------------------------------------------
    // write channel
    // ---------------------------------------------------------------------------
    assign aw_fire  = req.awvalid && req.wvalid && !bvalid_q;
    assign word_idx = req.awaddr[`AXIL_AW-1:2];
    assign in_range = (word_idx < WORD_LIMIT);
    assign strb_ok  = &req.wstrb;     // only whole words are accepted.
    assign wr_ok    = in_range && strb_ok;

    always_comb begin
        wr.en   = aw_fire && wr_ok;
        wr.idx  = req.awaddr[`IMEM_AW+3:4];
        wr.lane = req.awaddr[3:2];
        wr.data = req.wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            bresp_q  <= resp_okay;
        end else if (bvalid_q) begin
            if (req.bready) bvalid_q <= 1'b0;
        end else if (aw_fire) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_ok ? resp_okay : resp_slverr;
        end
    end

    // ---------------------------------------------------------------------------
    // read channel, which has nothing behind it.
    // ---------------------------------------------------------------------------
    assign ar_fire = req.arvalid && !rvalid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else if (rvalid_q) begin
            if (req.rready) rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end
    end

    always_comb begin
        rsp.awready = aw_fire;
        rsp.wready  = aw_fire;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = bresp_q;
        rsp.arready = ar_fire;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = '0;
        rsp.rresp   = resp_slverr;
    end

endmodule

/* logic/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ---------------------------------------------------------------------------
// instruction memory geometry
// ---------------------------------------------------------------------------
`define IMEM_DEPTH 1024  // number of 128-bit bundles, a power of two.
`define IMEM_AW    10    // bundle address width.

// ---------------------------------------------------------------------------
// return stack and fetch start
// ---------------------------------------------------------------------------
`define RAS_DEPTH  8     // stack entries, a power of two.
`define RESET_PC   0     // first bundle fetched after reset.

// loader bus address width.
`define AXIL_AW    32

`endif

/* logic/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

    // function codes of the jump group, slot bits 5:3.
    typedef enum logic [2:0] {
        jf_jump = 3'b000,
        jf_call = 3'b010,
        jf_ret  = 3'b100
    } jump_funct_e;

    // major op, slot bits 2:0. anything but op_jump is an ordinary operation.
    typedef enum logic [2:0] {
        op_alu  = 3'b000,
        op_jump = 3'b111
    } major_op_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic                valid;
        logic [`IMEM_AW-1:0] pc;
        logic [127:0]        inst;
    } fetch_bundle_t;

    typedef struct packed {
        logic                en;
        logic [`IMEM_AW-1:0] idx;   // bundle index.
        logic [1:0]          lane;  // lane 3 is slot 0.
        logic [31:0]         data;
    } imem_wr_t;

    typedef struct packed {
        logic                awvalid;
        logic [`AXIL_AW-1:0] awaddr;
        logic                wvalid;
        logic [31:0]         wdata;
        logic [3:0]          wstrb;
        logic                bready;
        logic                arvalid;
        logic [`AXIL_AW-1:0] araddr;
        logic                rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_e  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_e  rresp;
    } axil_rsp_t;

endpackage

/* logic/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  axil_req_t           axil_req,
    output axil_rsp_t           axil_rsp,
    input  logic                stall,
    input  logic                redirect_en,
    input  logic [`IMEM_AW-1:0] redirect_pc,
    output fetch_bundle_t       bundle
);

    imem_wr_t            mem_wr;
    logic                rd_en;
    logic [`IMEM_AW-1:0] rd_addr;
    logic [127:0]        mem_data;
    logic                ras_push;
    logic                ras_pop;
    logic [`IMEM_AW-1:0] ras_push_addr;
    logic [`IMEM_AW-1:0] ras_top;

    axil_imem_loader u_loader (
        .clk (clk),
        .rst (rst),
        .req (axil_req),
        .rsp (axil_rsp),
        .wr  (mem_wr)
    );

    imem_bank u_imem (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (mem_data),
        .wr      (mem_wr)
    );

    rastack u_ras (
        .clk       (clk),
        .rst       (rst),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (ras_push_addr),
        .top       (ras_top)
    );

    ifetch u_fetch (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .redirect_en   (redirect_en),
        .redirect_pc   (redirect_pc),
        .mem_data      (mem_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .bundle        (bundle),
        .ras_push      (ras_push),
        .ras_pop       (ras_pop),
        .ras_push_addr (ras_push_addr),
        .ras_top       (ras_top)
    );

endmodule

/* logic/ifetch.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module ifetch
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                redirect_en,
    input  logic [`IMEM_AW-1:0] redirect_pc,
    input  logic [127:0]        mem_data,
    output logic                rd_en,
    output logic [`IMEM_AW-1:0] rd_addr,
    output fetch_bundle_t       bundle,
    output logic                ras_push,
    output logic                ras_pop,
    output logic [`IMEM_AW-1:0] ras_push_addr,
    input  logic [`IMEM_AW-1:0] ras_top
);

    logic                valid_q;
    logic [`IMEM_AW-1:0] pc_q;      // address of the bundle now in mem_data.
    logic [`IMEM_AW-1:0] seq_pc;    // pc_q plus one, or RESET_PC before the first fetch.

    logic [31:0]         slot0;
    major_op_e           op;
    jump_funct_e         funct;
    logic [`IMEM_AW-1:0] target;
    logic                predec_ok;
    logic                take_jump;
    logic                take_call;
    logic                take_ret;

    // ---------------------------------------------------------------------------
    // slot 0 predecode
    // ---------------------------------------------------------------------------
    assign slot0  = mem_data[127:96];
    assign op     = major_op_e'(slot0[2:0]);
    assign funct  = jump_funct_e'(slot0[5:3]);
    assign target = slot0[6 +: `IMEM_AW];

    // a redirect hides whatever the current bundle says.
    assign predec_ok = valid_q && !redirect_en && (op == op_jump);
    assign take_jump = predec_ok && (funct == jf_jump);
    assign take_call = predec_ok && (funct == jf_call);
    assign take_ret  = predec_ok && (funct == jf_ret);

    always_comb begin
        if (redirect_en) begin
            rd_addr = redirect_pc;
        end else if (take_jump || take_call) begin
            rd_addr = target;
        end else if (take_ret) begin
            rd_addr = ras_top;
        end else begin
            rd_addr = seq_pc;
        end
    end

    assign rd_en         = !stall;
    assign ras_push      = !stall && take_call;
    assign ras_pop       = !stall && take_ret;
    assign ras_push_addr = seq_pc;  // return lands after the call.

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            pc_q    <= `IMEM_AW'(`RESET_PC);
            seq_pc  <= `IMEM_AW'(`RESET_PC);
        end else if (!stall) begin
            valid_q <= 1'b1;
            pc_q    <= rd_addr;
            seq_pc  <= rd_addr + 1'b1;
        end
    end

    always_comb begin
        bundle.valid = valid_q;
        bundle.pc    = pc_q;
        bundle.inst  = mem_data;
    end

endmodule

/* logic/imem_bank.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module imem_bank
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en,
    input  logic [`IMEM_AW-1:0] rd_addr,
    output logic [127:0]        rd_data,
    input  imem_wr_t            wr
);

    logic [127:0] mem [`IMEM_DEPTH];

    // read port, frozen while the fetch unit is stalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];  // old contents win on a same-cycle write.
        end
    end

    // ---------------------------------------------------------------------------
    // lane write port
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.idx][wr.lane*32 +: 32] <= wr.data;
        end
    end

endmodule

/* logic/rastack.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module rastack (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                pop,
    input  logic [`IMEM_AW-1:0] push_addr,
    output logic [`IMEM_AW-1:0] top
);

    localparam int PW = $clog2(`RAS_DEPTH);

    logic [`IMEM_AW-1:0] entries [`RAS_DEPTH];
    logic [PW-1:0]       ptr;       // points at the top entry.
    logic [PW-1:0]       ptr_inc;
    logic [PW-1:0]       ptr_dec;

    assign ptr_inc = ptr + 1'b1;    // wraps, so overflow drops the oldest entry.
    assign ptr_dec = ptr - 1'b1;
    assign top     = entries[ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (push && !pop) begin
            ptr <= ptr_inc;
        end else if (pop && !push) begin
            ptr <= ptr_dec;
        end
    end

    // a simultaneous push and pop replaces the top in place.
    always_ff @(posedge clk) begin
        if (push && pop) begin
            entries[ptr] <= push_addr;
        end else if (push) begin
            entries[ptr_inc] <= push_addr;
        end
    end

endmodule

/* verif/fetch_properties.sv */
`timescale 1ns/1ns

module fetch_properties
    import fetch_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input axil_req_t req,
    input axil_rsp_t rsp,
    input imem_wr_t  wr
);

    // ---------------------------------------------------------------------------
    // write channel
    // ---------------------------------------------------------------------------
    bvalid_held: assert property (
        @(posedge clk) disable iff (rst)
        rsp.bvalid && !req.bready |=> rsp.bvalid
    ) else $error("bvalid dropped before bready");

    aw_ready_needs_both: assert property (
        @(posedge clk) disable iff (rst)
        rsp.awready |-> (req.awvalid && req.wvalid)
    ) else $error("awready raised without awvalid and wvalid");

    // a pending response blocks the next write.
    no_write_while_b: assert property (
        @(posedge clk) disable iff (rst)
        wr.en |-> !rsp.bvalid
    ) else $error("memory write issued while bvalid pending");

    // the read channel has no memory behind it.
    read_is_slverr: assert property (
        @(posedge clk) disable iff (rst)
        rsp.rvalid |-> (rsp.rresp == resp_slverr)
    ) else $error("read response is not SLVERR");

endmodule

/* verif/fetch_tb.sv */
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int NUM_BUNDLES     = 64;   // program loaded before fetching starts.
    localparam int PERIOD          = 20;
    localparam int WATCHDOG_CYCLES = 2 + NUM_BUNDLES * 4 * 4 + 16 + 60 + 200;

    localparam logic [2:0] OP_JUMP = 3'b111;
    localparam logic [2:0] FN_JUMP = 3'b000;
    localparam logic [2:0] FN_CALL = 3'b010;
    localparam logic [2:0] FN_RET  = 3'b100;
    localparam logic [1:0] OKAY    = 2'b00;
    localparam logic [1:0] SLVERR  = 2'b10;

    logic                clk;
    logic                rst;
    logic                stall;
    logic                redirect_en;
    logic [`IMEM_AW-1:0] redirect_pc;
    axil_req_t           axil_req;
    axil_rsp_t           axil_rsp;
    fetch_bundle_t       bundle;

    logic [127:0]        shadow [`IMEM_DEPTH];
    logic [`IMEM_AW-1:0] ras_model [$];
    logic                exp_valid;
    logic [`IMEM_AW-1:0] exp_pc;
    logic [31:0]         lfsr;
    int                  checks;
    int                  errors;
    int                  chk_mark;
    int                  err_mark;

    fetch_top DUT (
        .clk         (clk),
        .rst         (rst),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .stall       (stall),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .bundle      (bundle)
    );

    bind axil_imem_loader fetch_properties u_props (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp),
        .wr  (wr)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // ---------------------------------------------------------------------------
    // helpers
    // ---------------------------------------------------------------------------
    task automatic take_bits(input int n, output logic [31:0] v);
        logic fb;
        int   i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32 + x^22 + x^2 + x + 1.
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] encode(input logic [2:0] funct, input int target,
                                           input logic [31:0] rnd);
        return {rnd[31:20], 14'(target), funct, OP_JUMP};
    endfunction

    // slot 0 of each bundle. The call chain is 24 -> 44 -> 52 -> 60.
    function automatic logic [31:0] slot_word(input int b, input logic [31:0] rnd);
        case (b)
            8:          return encode(FN_JUMP, 20, rnd);
            24:         return encode(FN_CALL, 44, rnd);
            44:         return encode(FN_CALL, 52, rnd);
            52:         return encode(FN_CALL, 60, rnd);
            45, 53, 60: return encode(FN_RET, 0, rnd);
            default:    return {rnd[31:3], 3'b000};  // ordinary op.
        endcase
    endfunction

    function automatic logic [`IMEM_AW-1:0] next_fetch(
        input logic [`IMEM_AW-1:0] pc,
        input logic                valid,
        input logic [127:0]        inst,
        input logic                redir,
        input logic [`IMEM_AW-1:0] redir_pc,
        input logic [`IMEM_AW-1:0] top
    );
        logic [31:0]         slot0;
        logic [`IMEM_AW-1:0] seq;
        slot0 = inst[127:96];
        seq   = valid ? pc + 1'b1 : pc;  // before the first fetch pc is the reset address.
        if (redir) return redir_pc;
        if (valid && slot0[2:0] == OP_JUMP) begin
            if (slot0[5:3] == FN_JUMP || slot0[5:3] == FN_CALL) return slot0[6 +: `IMEM_AW];
            if (slot0[5:3] == FN_RET) return top;
        end
        return seq;
    endfunction

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        do begin
            @(posedge clk);
        end while (!axil_rsp.awready);
        check("wready", 128'(axil_rsp.wready), 128'(1'b1));
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
        axil_req.bready <= 1'b1;  // response is held a cycle before it is taken.
        @(posedge clk);
        check("bvalid", 128'(axil_rsp.bvalid), 128'(1'b1));
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [1:0] resp,
                             output logic [31:0] data);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!axil_rsp.rvalid);
        resp = axil_rsp.rresp;
        data = axil_rsp.rdata;
        axil_req.rready <= 1'b0;
    endtask

    task automatic drive(input logic stall_v, input logic redir, input logic [`IMEM_AW-1:0] pc);
        @(posedge clk);
        stall       <= stall_v;
        redirect_en <= redir;
        redirect_pc <= pc;
    endtask

    task automatic end_test(input int num, input string name);
        @(negedge clk);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    // ---------------------------------------------------------------------------
    // reference model and comparator, one step per clock
    // ---------------------------------------------------------------------------
    always @(posedge clk) begin
        logic [127:0]        cur;
        logic [`IMEM_AW-1:0] top;
        logic [`IMEM_AW-1:0] nxt;
        if (rst) begin
            exp_valid = 1'b0;
            exp_pc    = `IMEM_AW'(`RESET_PC);
            ras_model.delete();
        end else begin
            cur = exp_valid ? shadow[exp_pc] : '0;
            check("bundle.valid", 128'(bundle.valid), 128'(exp_valid));
            check("bundle.pc", 128'(bundle.pc), 128'(exp_pc));
            check("bundle.inst", bundle.inst, cur);
            if (!stall) begin
                top = (ras_model.size() > 0) ? ras_model[$] : '0;
                nxt = next_fetch(exp_pc, exp_valid, cur, redirect_en, redirect_pc, top);
                if (exp_valid && !redirect_en && cur[98:96] == OP_JUMP) begin
                    if (cur[101:99] == FN_CALL) begin
                        ras_model.push_back(exp_pc + 1'b1);
                    end else if (cur[101:99] == FN_RET && ras_model.size() > 0) begin
                        void'(ras_model.pop_back());
                    end
                end
                exp_valid = 1'b1;
                exp_pc    = nxt;
            end
        end
    end

    initial begin
        logic [1:0]  resp;
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] rdata;
        int          b;
        int          lane;
        int          i;
        rst         = 1'b1;
        stall       = 1'b1;  // fetch stays frozen while the program loads.
        redirect_en = 1'b0;
        redirect_pc = '0;
        axil_req    = '0;
        lfsr        = 32'hebd9;
        checks      = 0;
        errors      = 0;
        chk_mark    = 0;
        err_mark    = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (b = 0; b < NUM_BUNDLES; b++) begin
            for (lane = 0; lane < 4; lane++) begin
                take_bits(32, rnd);
                word = (lane == 3) ? slot_word(b, rnd) : rnd;
                axil_write(32'(b * 16 + lane * 4), word, 4'hf, resp);
                check("bresp", 128'(resp), 128'(OKAY));
                shadow[b][lane*32 +: 32] = word;
            end
        end
        axil_write(32'h0000_4024, 32'hdead_beef, 4'hf, resp);  // would alias bundle 2 lane 1.
        check("bresp", 128'(resp), 128'(SLVERR));
        axil_write(32'h0000_0030, 32'hcafe_f00d, 4'b0011, resp);
        check("bresp", 128'(resp), 128'(SLVERR));
        axil_read(32'h0000_0000, resp, rdata);
        check("rresp", 128'(resp), 128'(SLVERR));
        check("rdata", 128'(rdata), 128'h0);
        end_test(1, "loader responses");

        repeat (9) drive(1'b0, 1'b0, '0);  // bundles 0 to 8.
        end_test(2, "sequential fetch");
        repeat (5) drive(1'b0, 1'b0, '0);  // 8 jumps to 20, then up to 24.
        end_test(3, "absolute jump");
        repeat (7) drive(1'b0, 1'b0, '0);
        end_test(4, "call and return");

        for (i = 0; i < 12; i++) begin
            take_bits(1, rnd);
            drive(rnd[0], 1'b0, '0);
        end
        drive(1'b0, 1'b1, `IMEM_AW'(8));
        drive(1'b0, 1'b1, `IMEM_AW'(30));  // beats the jump to 20 held in bundle 8.
        repeat (2) drive(1'b1, 1'b0, '0);
        end_test(5, "stall and redirect");

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
